// File: src.f
source/ldpcPkg.sv
source/regBusIf.sv
source/axiLiteSlave.sv
source/ldpcRegs.sv
source/outputEnGen.sv
source/ldpcCtrlTop.sv
tb/clkGen.sv
tb/ldpcChecker.sv
tb/ldpcCtrlTb.sv

// File: tb/ldpcCtrlTb.sv
`default_nettype none
`timescale 1ns/1ns

module ldpcCtrlTb;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} opT;

    // Status packs {inSync, ldpcReady, rotation, syncState}. OP_WAIT uses data as a cycle count.
    typedef struct packed {
        opT                op;
        ldpcPkg::busAddrT  addr;
        ldpcPkg::busDataT  data;
        ldpcPkg::byteStrbT strb;
        logic [5:0]        status;
    } entryT;

    logic                   busClk, arstN;
    ldpcPkg::busAddrT       awaddr, araddr;
    ldpcPkg::busDataT       wdata, rdata;
    ldpcPkg::byteStrbT      wstrb;
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    logic                   arvalid, arready, rvalid, rready;
    logic [1:0]             bresp, rresp;
    logic                   inSync, ldpcReady, outputEn;
    ldpcPkg::syncStateT     syncState;
    ldpcPkg::rotationT      rotation;
    logic                   codeLength4096, invertData, ldpcRun;
    ldpcPkg::codeRateT      codeRate;
    ldpcPkg::derandModeT    derandMode;
    ldpcPkg::syncThresholdT syncThreshold;
    ldpcPkg::mantissaT      inverseMeanMantissa;
    ldpcPkg::exponentT      inverseMeanExponent;
    ldpcPkg::clkDivT        outputEnClkDiv;
    int                     checkCount, errorCount;
    int                     cycleCount = 0;
    int                     cycleLimit = 2000;
    entryT                  stimTable[$];

    clkGen u_clkGen (
        .busClk (busClk),
        .arstN  (arstN)
    );

    ldpcCtrlTop u_dut (.*);

    ldpcChecker u_checker (.*);

    always @(posedge busClk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic addEntry(input opT op, input ldpcPkg::busAddrT addr,
                            input ldpcPkg::busDataT data, input ldpcPkg::byteStrbT strb,
                            input logic [5:0] status);
        stimTable.push_back('{op, addr, data, strb, status});
    endtask

    task automatic buildTable();
        addEntry(OP_READ,  ldpcPkg::LDPC_CONTROL,        32'h0,         4'h0, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_INVERSE_MEAN,   32'h0,         4'h0, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'h0,         4'h0, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_STATUS,         32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h7FFF_FFFF, 4'hF, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_CONTROL,        32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_INVERSE_MEAN,   32'hFFFF_FFFF, 4'hF, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_INVERSE_MEAN,   32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'hDEAD_BEEF, 4'hF, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h0,         4'h4, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_CONTROL,        32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_INVERSE_MEAN,   32'h1234_5678, 4'h2, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_INVERSE_MEAN,   32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'h0000_0003, 4'h1, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'h0,         4'h0, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_STATUS,         32'h0,         4'h0, 6'h2D);
        addEntry(OP_WRITE, ldpcPkg::LDPC_STATUS,         32'hFFFF_FFFF, 4'hF, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_STATUS,         32'h0,         4'h0, 6'h3F);
        addEntry(OP_WRITE, 13'h010,                      32'hFFFF_FFFF, 4'hF, 6'h00);
        addEntry(OP_READ,  13'h010,                      32'h0,         4'h0, 6'h12);
        addEntry(OP_READ,  13'h1FFC,                     32'h0,         4'h0, 6'h00);
        addEntry(OP_READ,  13'h005,                      32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'h0,         4'hF, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h8000_0000, 4'h8, 6'h00);
        addEntry(OP_WAIT,  13'h000,                      32'd12,        4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h0,         4'h8, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'd3,         4'hF, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h8000_0000, 4'h8, 6'h00);
        addEntry(OP_WAIT,  13'h000,                      32'd20,        4'h0, 6'h00);
        addEntry(OP_READ,  ldpcPkg::LDPC_CONTROL,        32'h0,         4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h0,         4'h8, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_OUTPUT_CLK_DIV, 32'd9,         4'hF, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h8000_0000, 4'h8, 6'h00);
        addEntry(OP_WAIT,  13'h000,                      32'd40,        4'h0, 6'h00);
        addEntry(OP_WRITE, ldpcPkg::LDPC_CONTROL,        32'h0,         4'h8, 6'h00);
        addEntry(OP_WAIT,  13'h000,                      32'd5,         4'h0, 6'h00);
    endtask

    // Every task starts and ends 1 ns after a rising edge.
    task automatic writeReg(input ldpcPkg::busAddrT addr, input ldpcPkg::busDataT data,
                            input ldpcPkg::byteStrbT strb);
        int stall;
        stall   = $urandom_range(3, 0);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge busClk);
        while (!(awready && wready)) begin
            @(posedge busClk);
        end
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (stall) begin
            @(posedge busClk);
            #1;
        end
        bready = 1'b1;
        @(posedge busClk);
        while (!bvalid) begin
            @(posedge busClk);
        end
        #1;
        bready = 1'b0;
    endtask

    task automatic readReg(input ldpcPkg::busAddrT addr);
        int stall;
        stall   = $urandom_range(3, 0);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge busClk);
        while (!arready) begin
            @(posedge busClk);
        end
        #1;
        arvalid = 1'b0;
        repeat (stall) begin
            @(posedge busClk);
            #1;
        end
        rready = 1'b1;
        @(posedge busClk);
        while (!rvalid) begin
            @(posedge busClk);
        end
        #1;
        rready = 1'b0;
    endtask

    initial begin
        int    errorsBefore;
        entryT entry;
        void'($urandom(38));
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        inSync    = 1'b0;
        ldpcReady = 1'b0;
        syncState = '0;
        rotation  = '0;
        buildTable();
        cycleLimit = 30 * stimTable.size() + 2000;
        wait (arstN);
        @(posedge busClk);
        #1;
        foreach (stimTable[i]) begin
            entry        = stimTable[i];
            errorsBefore = errorCount;
            {inSync, ldpcReady, rotation, syncState} = entry.status;
            case (entry.op)
                OP_WRITE: writeReg(entry.addr, entry.data, entry.strb);
                OP_READ:  readReg(entry.addr);
                default: begin
                    repeat (entry.data) @(posedge busClk);
                    #1;
                end
            endcase
            $display("Test %0d %s addr 0x%03h: %s", i, entry.op.name(), entry.addr,
                     (errorCount == errorsBefore) ? "ok" : "errors found");
        end
        repeat (3) @(posedge busClk);
        $display("Done: %0d tests, %0d checks, %0d errors",
                 stimTable.size(), checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/ldpcChecker.sv
`default_nettype none
`timescale 1ns/1ns

module ldpcChecker (
    input  wire logic                   busClk, arstN,
    input  wire logic                   awvalid, awready, wvalid, wready, bvalid, bready,
    input  wire logic                   arvalid, arready, rvalid, rready,
    input  wire ldpcPkg::busAddrT       awaddr, araddr,
    input  wire ldpcPkg::busDataT       wdata, rdata,
    input  wire ldpcPkg::byteStrbT      wstrb,
    input  wire logic [1:0]             bresp, rresp,
    input  wire logic                   inSync, ldpcReady, outputEn,
    input  wire ldpcPkg::syncStateT     syncState,
    input  wire ldpcPkg::rotationT      rotation,
    input  wire logic                   codeLength4096, invertData, ldpcRun,
    input  wire ldpcPkg::codeRateT      codeRate,
    input  wire ldpcPkg::derandModeT    derandMode,
    input  wire ldpcPkg::syncThresholdT syncThreshold,
    input  wire ldpcPkg::mantissaT      inverseMeanMantissa,
    input  wire ldpcPkg::exponentT      inverseMeanExponent,
    input  wire ldpcPkg::clkDivT        outputEnClkDiv,
    output int                          checkCount, errorCount
);

    // Shadow images of the three writable registers.
    ldpcPkg::busDataT ctrlImage;
    ldpcPkg::busDataT invImage;
    ldpcPkg::busDataT divImage;
    ldpcPkg::busDataT expectedReads[$];
    ldpcPkg::busDataT heldRdata;
    logic             rHeld;
    logic             bHeld;
    logic             wrExpected;
    int               writesPending;
    int               runCycles;

    initial begin
        checkCount = 0;
        errorCount = 0;
    end

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reportError(input string what);
        errorCount++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // Bits that a write can change, per register.
    function automatic ldpcPkg::busDataT writeMask(input ldpcPkg::busAddrT regAddr);
        case (regAddr)
            ldpcPkg::LDPC_CONTROL:        return 32'h87FF_00BB;
            ldpcPkg::LDPC_INVERSE_MEAN:   return 32'h0007_FFFF;
            ldpcPkg::LDPC_OUTPUT_CLK_DIV: return 32'h0000_FFFF;
            default:                      return 32'h0;
        endcase
    endfunction

    function automatic ldpcPkg::busDataT mergeWrite(input ldpcPkg::busDataT image,
                                                    input ldpcPkg::busAddrT regAddr);
        ldpcPkg::busDataT laneMask;
        laneMask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
        if ({awaddr[12:2], 2'b00} != regAddr) begin
            laneMask = '0;
        end
        laneMask = laneMask & writeMask(regAddr);
        return (image & ~laneMask) | (wdata & laneMask);
    endfunction

    function automatic ldpcPkg::busDataT expectedRead(input ldpcPkg::busAddrT addr);
        case ({addr[12:2], 2'b00})
            ldpcPkg::LDPC_CONTROL:        return ctrlImage;
            ldpcPkg::LDPC_INVERSE_MEAN:   return invImage;
            ldpcPkg::LDPC_OUTPUT_CLK_DIV: return divImage;
            ldpcPkg::LDPC_STATUS:
                return {inSync, ldpcReady, 20'h0, rotation, 6'h0, syncState};
            default:                      return '0;
        endcase
    endfunction

    always @(posedge busClk) begin
        if (!arstN) begin
            ctrlImage     = '0;
            invImage      = '0;
            divImage      = '0;
            rHeld         = 1'b0;
            bHeld         = 1'b0;
            writesPending = 0;
            runCycles     = 0;
            expectedReads.delete();
        end else begin
            compareValue("codeRate", ctrlImage[1:0], codeRate);
            compareValue("codeLength4096", ctrlImage[3], codeLength4096);
            compareValue("derandMode", ctrlImage[5:4], derandMode);
            compareValue("invertData", ctrlImage[7], invertData);
            compareValue("syncThreshold", ctrlImage[26:16], syncThreshold);
            compareValue("ldpcRun", ctrlImage[31], ldpcRun);
            compareValue("inverseMeanMantissa", invImage[15:0], inverseMeanMantissa);
            compareValue("inverseMeanExponent", invImage[18:16], inverseMeanExponent);
            compareValue("outputEnClkDiv", divImage[15:0], outputEnClkDiv);

            // The first pulse and every later one are divider+1 cycles apart.
            if (!ldpcRun) begin
                compareValue("outputEn", 32'h0, outputEn);
                runCycles = 0;
            end else if (outputEn) begin
                compareValue("outputEn spacing", divImage[15:0] + 32'd1, runCycles);
                runCycles = 1;
            end else begin
                runCycles++;
                if (runCycles > divImage[15:0] + 1) begin
                    reportError("outputEn pulse missing while the decoder runs");
                    runCycles = 0;
                end
            end

            // Responses are pending exactly while an accepted transfer is unanswered.
            wrExpected = awvalid && wvalid && (writesPending == 0);
            compareValue("awready", wrExpected, awready);
            compareValue("wready", wrExpected, wready);
            compareValue("arready",
                         arvalid && (expectedReads.size() == 0) && !wrExpected, arready);
            compareValue("bvalid", writesPending != 0, bvalid);
            compareValue("rvalid", expectedReads.size() != 0, rvalid);

            if (bHeld && !bvalid) begin
                reportError("bvalid dropped before bready");
            end
            if (rHeld) begin
                compareValue("rvalid", 32'h1, rvalid);
                compareValue("rdata while stalled", heldRdata, rdata);
            end
            bHeld     = bvalid && !bready;
            rHeld     = rvalid && !rready;
            heldRdata = rdata;

            if (bvalid && bready) begin
                compareValue("bresp", ldpcPkg::RESP_OKAY, bresp);
                if (writesPending == 0) begin
                    reportError("write response without a pending write");
                end else begin
                    writesPending--;
                end
            end
            if (rvalid && rready) begin
                compareValue("rresp", ldpcPkg::RESP_OKAY, rresp);
                if (expectedReads.size() == 0) begin
                    reportError("read response without a pending read");
                end else begin
                    compareValue("rdata", expectedReads.pop_front(), rdata);
                end
            end
            if (arvalid && arready) begin
                expectedReads.push_back(expectedRead(araddr));
            end
            if (awvalid && awready && wvalid && wready) begin
                writesPending++;
                ctrlImage = mergeWrite(ctrlImage, ldpcPkg::LDPC_CONTROL);
                invImage  = mergeWrite(invImage, ldpcPkg::LDPC_INVERSE_MEAN);
                divImage  = mergeWrite(divImage, ldpcPkg::LDPC_OUTPUT_CLK_DIV);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/clkGen.sv
`default_nettype none
`timescale 1ns/1ns

// Free-running bus clock with a reset held over the first few edges.
module clkGen (
    output logic busClk,
    output logic arstN
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        busClk = 1'b0;
        forever begin
            #HALF_PERIOD busClk = ~busClk;
        end
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge busClk);
        #1;
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: source/ldpcCtrlTop.sv
`default_nettype none
`timescale 1ns/1ns

module ldpcCtrlTop (
    input  wire logic                   busClk,
    input  wire logic                   arstN,

    input  wire ldpcPkg::busAddrT       awaddr,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire ldpcPkg::busDataT       wdata,
    input  wire ldpcPkg::byteStrbT      wstrb,
    input  wire logic                   wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire logic                   bready,
    input  wire ldpcPkg::busAddrT       araddr,
    input  wire logic                   arvalid,
    output logic                        arready,
    output ldpcPkg::busDataT            rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire logic                   rready,

    input  wire logic                   inSync,
    input  wire logic                   ldpcReady,
    input  wire ldpcPkg::syncStateT     syncState,
    input  wire ldpcPkg::rotationT      rotation,

    output logic                        codeLength4096,
    output logic                        invertData,
    output logic                        ldpcRun,
    output ldpcPkg::codeRateT           codeRate,
    output ldpcPkg::derandModeT         derandMode,
    output ldpcPkg::syncThresholdT      syncThreshold,
    output ldpcPkg::mantissaT           inverseMeanMantissa,
    output ldpcPkg::exponentT           inverseMeanExponent,
    output ldpcPkg::clkDivT             outputEnClkDiv,
    output logic                        outputEn
);

    regBusIf regBus ();

    axiLiteSlave u_axiLiteSlave (
        .busClk  (busClk),
        .arstN   (arstN),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (regBus.host)
    );

    ldpcRegs u_ldpcRegs (
        .busClk              (busClk),
        .arstN               (arstN),
        .bus                 (regBus.regs),
        .inSync              (inSync),
        .ldpcReady           (ldpcReady),
        .syncState           (syncState),
        .rotation            (rotation),
        .codeLength4096      (codeLength4096),
        .invertData          (invertData),
        .ldpcRun             (ldpcRun),
        .codeRate            (codeRate),
        .derandMode          (derandMode),
        .syncThreshold       (syncThreshold),
        .inverseMeanMantissa (inverseMeanMantissa),
        .inverseMeanExponent (inverseMeanExponent),
        .outputEnClkDiv      (outputEnClkDiv)
    );

    outputEnGen u_outputEnGen (
        .busClk         (busClk),
        .arstN          (arstN),
        .ldpcRun        (ldpcRun),
        .outputEnClkDiv (outputEnClkDiv),
        .outputEn       (outputEn)
    );

endmodule

`default_nettype wire

// File: source/outputEnGen.sv
`default_nettype none
`timescale 1ns/1ns

module outputEnGen (
    input  wire logic            busClk,
    input  wire logic            arstN,
    input  wire logic            ldpcRun,
    input  wire ldpcPkg::clkDivT outputEnClkDiv,
    output logic                 outputEn
);

    ldpcPkg::clkDivT count;
    logic            armed;

    // The first running edge loads the divider, so the first pulse lands
    // divider+1 cycles after ldpcRun rises. After that the counter reloads
    // at zero, giving one pulse every divider+1 cycles.
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
            armed <= 1'b0;
        end else if (!ldpcRun) begin
            count <= '0;
            armed <= 1'b0;
        end else if (!armed || count == '0) begin
            count <= outputEnClkDiv;
            armed <= 1'b1;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign outputEn = ldpcRun & armed & (count == '0);

    runGateCheck: assert property (
        @(posedge busClk) disable iff (!arstN)
        outputEn |-> ldpcRun
    ) else $error("outputEn high while the decoder is stopped");

endmodule

`default_nettype wire

// File: source/ldpcRegs.sv
`default_nettype none
`timescale 1ns/1ns

module ldpcRegs (
    input  wire logic                   busClk,
    input  wire logic                   arstN,

    regBusIf.regs                       bus,

    input  wire logic                   inSync,
    input  wire logic                   ldpcReady,
    input  wire ldpcPkg::syncStateT     syncState,
    input  wire ldpcPkg::rotationT      rotation,

    output logic                        codeLength4096,
    output logic                        invertData,
    output logic                        ldpcRun,
    output ldpcPkg::codeRateT           codeRate,
    output ldpcPkg::derandModeT         derandMode,
    output ldpcPkg::syncThresholdT      syncThreshold,
    output ldpcPkg::mantissaT           inverseMeanMantissa,
    output ldpcPkg::exponentT           inverseMeanExponent,
    output ldpcPkg::clkDivT             outputEnClkDiv
);

    ldpcPkg::busAddrT regAddr;

    // Word address only, byte offset bits are dropped.
    assign regAddr = {bus.addr[12:2], 2'b00};

    // Each lane only touches the fields that live in its byte.
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            codeRate            <= '0;
            codeLength4096      <= 1'b0;
            derandMode          <= '0;
            invertData          <= 1'b0;
            syncThreshold       <= '0;
            ldpcRun             <= 1'b0;
            inverseMeanMantissa <= '0;
            inverseMeanExponent <= '0;
            outputEnClkDiv      <= '0;
        end else if (bus.cs) begin
            case (regAddr)
                ldpcPkg::LDPC_CONTROL: begin
                    if (bus.wrStrb[0]) begin
                        codeRate       <= bus.wrData[1:0];
                        codeLength4096 <= bus.wrData[3];
                        derandMode     <= bus.wrData[5:4];
                        invertData     <= bus.wrData[7];
                    end
                    if (bus.wrStrb[2]) begin
                        syncThreshold[7:0] <= bus.wrData[23:16];
                    end
                    if (bus.wrStrb[3]) begin
                        syncThreshold[10:8] <= bus.wrData[26:24];
                        ldpcRun             <= bus.wrData[31];
                    end
                end
                ldpcPkg::LDPC_INVERSE_MEAN: begin
                    if (bus.wrStrb[0]) begin
                        inverseMeanMantissa[7:0] <= bus.wrData[7:0];
                    end
                    if (bus.wrStrb[1]) begin
                        inverseMeanMantissa[15:8] <= bus.wrData[15:8];
                    end
                    if (bus.wrStrb[2]) begin
                        inverseMeanExponent <= bus.wrData[18:16];
                    end
                end
                ldpcPkg::LDPC_OUTPUT_CLK_DIV: begin
                    if (bus.wrStrb[0]) begin
                        outputEnClkDiv[7:0] <= bus.wrData[7:0];
                    end
                    if (bus.wrStrb[1]) begin
                        outputEnClkDiv[15:8] <= bus.wrData[15:8];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        bus.rdData = '0;
        if (bus.cs) begin
            case (regAddr)
                ldpcPkg::LDPC_CONTROL: begin
                    bus.rdData[1:0]   = codeRate;
                    bus.rdData[3]     = codeLength4096;
                    bus.rdData[5:4]   = derandMode;
                    bus.rdData[7]     = invertData;
                    bus.rdData[26:16] = syncThreshold;
                    bus.rdData[31]    = ldpcRun;
                end
                ldpcPkg::LDPC_INVERSE_MEAN: begin
                    bus.rdData[15:0]  = inverseMeanMantissa;
                    bus.rdData[18:16] = inverseMeanExponent;
                end
                ldpcPkg::LDPC_OUTPUT_CLK_DIV: begin
                    bus.rdData[15:0] = outputEnClkDiv;
                end
                ldpcPkg::LDPC_STATUS: begin
                    bus.rdData[1:0] = syncState;
                    bus.rdData[9:8] = rotation;
                    bus.rdData[30]  = ldpcReady;
                    bus.rdData[31]  = inSync;
                end
                default: begin
                end
            endcase
        end
    end

    strbCsCheck: assert property (
        @(posedge busClk) disable iff (!arstN)
        !bus.cs |-> bus.wrStrb == '0
    ) else $error("byte strobes active outside an access");

endmodule

`default_nettype wire

// File: source/axiLiteSlave.sv
`default_nettype none
`timescale 1ns/1ns

module axiLiteSlave (
    input  wire logic              busClk,
    input  wire logic              arstN,

    input  wire ldpcPkg::busAddrT  awaddr,
    input  wire logic              awvalid,
    output logic                   awready,

    input  wire ldpcPkg::busDataT  wdata,
    input  wire ldpcPkg::byteStrbT wstrb,
    input  wire logic              wvalid,
    output logic                   wready,

    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire logic              bready,

    input  wire ldpcPkg::busAddrT  araddr,
    input  wire logic              arvalid,
    output logic                   arready,

    output ldpcPkg::busDataT       rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire logic              rready,

    regBusIf.host                  bus
);

    logic wrAccept;
    logic rdAccept;

    // A write needs both address and data present, and the previous response
    // must have been taken. Writes win over a read in the same cycle.
    assign wrAccept = awvalid & wvalid & ~bvalid;
    assign rdAccept = arvalid & ~rvalid & ~wrAccept;

    assign awready = wrAccept;
    assign wready  = wrAccept;
    assign arready = rdAccept;

    assign bus.cs     = wrAccept | rdAccept;
    assign bus.wrStrb = wrAccept ? wstrb : '0;
    assign bus.addr   = wrAccept ? awaddr : araddr;
    assign bus.wrData = wdata;

    // Every transfer completes normally, mapped or not.
    assign bresp = ldpcPkg::RESP_OKAY;
    assign rresp = ldpcPkg::RESP_OKAY;

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            bvalid <= 1'b0;
        end else if (wrAccept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            rvalid <= 1'b0;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // The register block answers combinationally during the read cycle.
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            rdata <= '0;
        end else if (rdAccept) begin
            rdata <= bus.rdData;
        end
    end

    bHoldCheck: assert property (
        @(posedge busClk) disable iff (!arstN)
        bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

    rHoldCheck: assert property (
        @(posedge busClk) disable iff (!arstN)
        rvalid && !rready |=> rvalid && $stable(rdata)
    ) else $error("read response changed before rready");

endmodule

`default_nettype wire

// File: source/regBusIf.sv
`default_nettype none
`timescale 1ns/1ns

// Local register bus. A cycle with cs high and a nonzero wrStrb is a write,
// and with a zero wrStrb it is a read sampled at the end of the cycle.
interface regBusIf;

    logic              cs;
    ldpcPkg::byteStrbT wrStrb;
    ldpcPkg::busAddrT  addr;
    ldpcPkg::busDataT  wrData;
    ldpcPkg::busDataT  rdData;

    modport host (
        output cs,
        output wrStrb,
        output addr,
        output wrData,
        input  rdData
    );

    modport regs (
        input  cs,
        input  wrStrb,
        input  addr,
        input  wrData,
        output rdData
    );

endinterface

`default_nettype wire

// File: source/ldpcPkg.sv
`default_nettype none

package ldpcPkg;

    typedef logic [12:0] busAddrT;
    typedef logic [31:0] busDataT;
    typedef logic [3:0]  byteStrbT;

    typedef logic [1:0]  codeRateT;
    typedef logic [1:0]  derandModeT;
    typedef logic [10:0] syncThresholdT;
    typedef logic [15:0] mantissaT;
    typedef logic [2:0]  exponentT;
    typedef logic [15:0] clkDivT;
    typedef logic [1:0]  syncStateT;
    typedef logic [1:0]  rotationT;

    // Register byte addresses. Bits 1:0 are ignored by the decoder.
    localparam busAddrT LDPC_CONTROL        = 13'h000;
    localparam busAddrT LDPC_INVERSE_MEAN   = 13'h004;
    localparam busAddrT LDPC_OUTPUT_CLK_DIV = 13'h008;
    localparam busAddrT LDPC_STATUS         = 13'h00C;

    // AXI response code for a completed transfer.
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Field layout (bits, write lane):
    //   CONTROL         codeRate              1:0    lane 0
    //   CONTROL         codeLength4096        3      lane 0
    //   CONTROL         derandMode            5:4    lane 0
    //   CONTROL         invertData            7      lane 0
    //   CONTROL         syncThreshold[7:0]    23:16  lane 2
    //   CONTROL         syncThreshold[10:8]   26:24  lane 3
    //   CONTROL         ldpcRun               31     lane 3
    //   INVERSE_MEAN    mantissa              15:0   lanes 0 and 1
    //   INVERSE_MEAN    exponent              18:16  lane 2
    //   OUTPUT_CLK_DIV  divider               15:0   lanes 0 and 1
    //   STATUS          syncState             1:0    read only
    //   STATUS          rotation              9:8    read only
    //   STATUS          ldpcReady             30     read only
    //   STATUS          inSync                31     read only
    // Every other bit reads as zero.

endpackage

`default_nettype wire
